// File: source/regmst_consts.svh
`ifndef REGMST_CONSTS_SVH
`define REGMST_CONSTS_SVH

// bus widths
`define REGMST_ADDR_W           64
`define REGMST_DATA_W           32

// word address map, word = paddr >> 2
// words 0 .. last word go to the downstream dispatcher
`define REGMST_EXT_LAST_WORD    'h431
// debug words start at byte address 0x2000
`define REGMST_DBG_BASE_WORD    'h800

// debug register file
`define REGMST_REG_NUM          4

// timeout threshold after reset
`define REGMST_TMR_THR_RST      32'd99

`endif

// File: source/regmst_bus_pkg.sv
`include "regmst_consts.svh"

package regmst_bus_pkg;

    // apb address and data words
    typedef logic [`REGMST_ADDR_W-1:0] addr_t;
    typedef logic [`REGMST_DATA_W-1:0] data_t;

    // where a decoded access goes
    typedef enum logic [1:0] {
        TGT_EXT,
        TGT_DBG,
        TGT_EMPTY
    } target_e;

endpackage

// File: source/regmst_reg_pkg.sv
`include "regmst_consts.svh"

package regmst_reg_pkg;

    // word offset inside the debug block
    typedef enum logic [$clog2(`REGMST_REG_NUM)-1:0] {
        REG_ERR_ADDR_LO = 0,
        REG_ERR_ADDR_HI = 1,
        REG_TMR_THR     = 2,
        REG_ERR_STAT    = 3
    } reg_idx_e;

    // error status word
    // err_type[1] is timeout, err_type[0] is the write flag of the failed access
    typedef struct packed {
        logic [`REGMST_DATA_W-5:0] rsvd;
        logic [1:0]                err_type;
        logic                      err_occur;
        logic                      soft_rst;
    } err_stat_t;

endpackage

// File: source/apb_access_fsm.sv
`timescale 1ns/1ps

module apb_access_fsm
    import regmst_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  psel_i,
    input  logic  penable_i,
    input  logic  pwrite_i,
    input  addr_t paddr_i,
    input  data_t pwdata_i,
    input  data_t tmr_thr_i,
    input  logic  ack_i,
    input  logic  ack_err_i,
    input  data_t ack_rdata_i,
    output logic  pready_o,
    output logic  pslverr_o,
    output data_t prdata_o,
    output logic  req_o,
    output logic  req_wr_o,
    output addr_t req_addr_o,
    output data_t req_wdata_o,
    output logic  timeout_o
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_e;

    state_e state_q;
    state_e state_d;
    data_t  tmr_cnt_q;
    logic   pslverr_q;
    data_t  prdata_q;
    logic   start;
    logic   tmr_hit;

    // access phase seen while nothing is in flight
    assign start   = (state_q == ST_IDLE) && psel_i && penable_i;
    // ack has priority over the timer
    assign tmr_hit = (state_q == ST_WAIT) && !ack_i && (tmr_cnt_q == tmr_thr_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (ack_i || tmr_hit) begin
                    state_d = ST_RESP;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            tmr_cnt_q <= '0;
            pslverr_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // cycles spent waiting for the ack
            if (start) begin
                tmr_cnt_q <= '0;
            end else if (state_q == ST_WAIT) begin
                tmr_cnt_q <= tmr_cnt_q + 1'b1;
            end
            if (state_q == ST_WAIT && ack_i) begin
                pslverr_q <= ack_err_i;
            end else if (tmr_hit) begin
                pslverr_q <= 1'b1;
            end else if (state_q == ST_RESP) begin
                pslverr_q <= 1'b0;
            end
        end
    end

    // latched transfer and read result
    always_ff @(posedge clk) begin
        if (start) begin
            req_wr_o    <= pwrite_i;
            req_addr_o  <= paddr_i;
            req_wdata_o <= pwdata_i;
        end
        if (state_q == ST_WAIT && ack_i) begin
            prdata_q <= ack_rdata_i;
        end else if (tmr_hit) begin
            prdata_q <= '0;
        end
    end

    assign req_o     = (state_q == ST_WAIT);
    assign timeout_o = tmr_hit;
    assign pready_o  = (state_q == ST_RESP);
    assign pslverr_o = pslverr_q;
    assign prdata_o  = prdata_q;

endmodule

// File: source/access_router.sv
`timescale 1ns/1ps
`include "regmst_consts.svh"

module access_router
    import regmst_bus_pkg::*;
    import regmst_reg_pkg::*;
(
    input  logic     req_i,
    input  logic     req_wr_i,
    input  addr_t    req_addr_i,
    input  data_t    req_wdata_i,
    input  logic     ext_ack_i,
    input  logic     ext_err_i,
    input  data_t    ext_rdata_i,
    input  data_t    reg_rdata_i,
    output logic     ack_o,
    output logic     ack_err_o,
    output data_t    ack_rdata_o,
    output logic     ext_req_o,
    output logic     ext_wr_en_o,
    output logic     ext_rd_en_o,
    output addr_t    ext_addr_o,
    output data_t    ext_wdata_o,
    output logic     reg_wr_o,
    output reg_idx_e reg_idx_o,
    output data_t    reg_wdata_o,
    output logic     empty_acc_o
);
    logic [`REGMST_ADDR_W-3:0] word;
    logic [`REGMST_ADDR_W-3:0] dbg_off;
    target_e                   tgt;

    assign word    = req_addr_i[`REGMST_ADDR_W-1:2];
    assign dbg_off = word - `REGMST_DBG_BASE_WORD;

    // address decode
    always_comb begin
        if (word <= `REGMST_EXT_LAST_WORD) begin
            tgt = TGT_EXT;
        end else if (word >= `REGMST_DBG_BASE_WORD && dbg_off < `REGMST_REG_NUM) begin
            tgt = TGT_DBG;
        end else begin
            tgt = TGT_EMPTY;
        end
    end

    assign reg_idx_o = reg_idx_e'(dbg_off[1:0]);

    // steer the request
    assign ext_req_o   = req_i && (tgt == TGT_EXT);
    assign ext_wr_en_o = ext_req_o && req_wr_i;
    assign ext_rd_en_o = ext_req_o && !req_wr_i;
    assign ext_addr_o  = req_addr_i;
    assign ext_wdata_o = req_wdata_i;
    assign reg_wr_o    = req_i && req_wr_i && (tgt == TGT_DBG);
    assign reg_wdata_o = req_wdata_i;
    assign empty_acc_o = req_i && (tgt == TGT_EMPTY);

    // merge the acknowledges
    // internal targets answer in the request cycle
    always_comb begin
        case (tgt)
            TGT_EXT: begin
                ack_o       = ext_req_o && ext_ack_i;
                ack_err_o   = ext_err_i;
                ack_rdata_o = ext_rdata_i;
            end
            TGT_DBG: begin
                ack_o       = req_i;
                ack_err_o   = 1'b0;
                ack_rdata_o = reg_rdata_i;
            end
            default: begin
                ack_o       = req_i;
                ack_err_o   = 1'b1;
                ack_rdata_o = '0;
            end
        endcase
    end

endmodule

// File: source/debug_reg_bank.sv
`timescale 1ns/1ps
`include "regmst_consts.svh"

module debug_reg_bank
    import regmst_bus_pkg::*;
    import regmst_reg_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     reg_wr_i,
    input  reg_idx_e reg_idx_i,
    input  data_t    reg_wdata_i,
    input  logic     req_wr_i,
    input  addr_t    req_addr_i,
    input  logic     timeout_i,
    input  logic     empty_acc_i,
    output data_t    reg_rdata_o,
    output data_t    tmr_thr_o,
    output logic     soft_rst_o
);
    addr_t     err_addr_q;
    data_t     tmr_thr_q;
    logic      soft_rst_q;
    logic      err_occur_q;
    logic [1:0] err_type_q;
    logic      thr_wr;
    logic      stat_wr;
    err_stat_t wr_stat;
    err_stat_t rd_stat;

    assign thr_wr  = reg_wr_i && (reg_idx_i == REG_TMR_THR);
    assign stat_wr = reg_wr_i && (reg_idx_i == REG_ERR_STAT);
    assign wr_stat = err_stat_t'(reg_wdata_i);

    // address of the access that hung, read only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_addr_q <= '0;
        end else if (timeout_i) begin
            err_addr_q <= req_addr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr_thr_q <= `REGMST_TMR_THR_RST;
        end else if (thr_wr) begin
            tmr_thr_q <= reg_wdata_i;
        end
    end

    // status word
    // a software write beats the hardware set of err_occur
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            soft_rst_q  <= 1'b0;
            err_occur_q <= 1'b0;
            err_type_q  <= 2'b00;
        end else begin
            if (stat_wr) begin
                soft_rst_q  <= wr_stat.soft_rst;
                err_occur_q <= wr_stat.err_occur;
            end else if (timeout_i) begin
                err_occur_q <= 1'b1;
            end
            // err_type only follows hardware events
            if (timeout_i) begin
                err_type_q <= {1'b1, req_wr_i};
            end else if (empty_acc_i) begin
                err_type_q <= {1'b0, req_wr_i};
            end
        end
    end

    always_comb begin
        rd_stat           = '0;
        rd_stat.soft_rst  = soft_rst_q;
        rd_stat.err_occur = err_occur_q;
        rd_stat.err_type  = err_type_q;
    end

    // read mux
    always_comb begin
        case (reg_idx_i)
            REG_ERR_ADDR_LO: reg_rdata_o = err_addr_q[`REGMST_DATA_W-1:0];
            REG_ERR_ADDR_HI: reg_rdata_o = err_addr_q[`REGMST_ADDR_W-1:`REGMST_DATA_W];
            REG_TMR_THR:     reg_rdata_o = tmr_thr_q;
            default:         reg_rdata_o = rd_stat;
        endcase
    end

    assign tmr_thr_o  = tmr_thr_q;
    assign soft_rst_o = soft_rst_q;

endmodule

// File: source/regmst_top.sv
`timescale 1ns/1ps

module regmst_top
    import regmst_bus_pkg::*;
    import regmst_reg_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // apb slave side
    input  logic  psel_i,
    input  logic  penable_i,
    input  logic  pwrite_i,
    input  addr_t paddr_i,
    input  data_t pwdata_i,
    output logic  pready_o,
    output logic  pslverr_o,
    output data_t prdata_o,

    // downstream dispatcher port
    output logic  ext_req_o,
    output logic  ext_wr_en_o,
    output logic  ext_rd_en_o,
    output addr_t ext_addr_o,
    output data_t ext_wdata_o,
    input  logic  ext_ack_i,
    input  logic  ext_err_i,
    input  data_t ext_rdata_i,
    output logic  ext_soft_rst_o
);
    // internal request
    logic     req;
    logic     req_wr;
    addr_t    req_addr;
    data_t    req_wdata;
    logic     ack;
    logic     ack_err;
    data_t    ack_rdata;
    logic     timeout;

    // debug bank access
    logic     reg_wr;
    reg_idx_e reg_idx;
    data_t    reg_wdata;
    data_t    reg_rdata;
    logic     empty_acc;
    data_t    tmr_thr;

    apb_access_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .tmr_thr_i   (tmr_thr),
        .ack_i       (ack),
        .ack_err_i   (ack_err),
        .ack_rdata_i (ack_rdata),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .prdata_o    (prdata_o),
        .req_o       (req),
        .req_wr_o    (req_wr),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .timeout_o   (timeout)
    );

    access_router u_router (
        .req_i       (req),
        .req_wr_i    (req_wr),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .ext_ack_i   (ext_ack_i),
        .ext_err_i   (ext_err_i),
        .ext_rdata_i (ext_rdata_i),
        .reg_rdata_i (reg_rdata),
        .ack_o       (ack),
        .ack_err_o   (ack_err),
        .ack_rdata_o (ack_rdata),
        .ext_req_o   (ext_req_o),
        .ext_wr_en_o (ext_wr_en_o),
        .ext_rd_en_o (ext_rd_en_o),
        .ext_addr_o  (ext_addr_o),
        .ext_wdata_o (ext_wdata_o),
        .reg_wr_o    (reg_wr),
        .reg_idx_o   (reg_idx),
        .reg_wdata_o (reg_wdata),
        .empty_acc_o (empty_acc)
    );

    debug_reg_bank u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr_i    (reg_wr),
        .reg_idx_i   (reg_idx),
        .reg_wdata_i (reg_wdata),
        .req_wr_i    (req_wr),
        .req_addr_i  (req_addr),
        .timeout_i   (timeout),
        .empty_acc_i (empty_acc),
        .reg_rdata_o (reg_rdata),
        .tmr_thr_o   (tmr_thr),
        .soft_rst_o  (ext_soft_rst_o)
    );

endmodule

// File: sim/regmst_asserts.sv
`timescale 1ns/1ps

module regmst_asserts (
    input logic clk,
    input logic rst_n,
    input logic pready_i,
    input logic ext_req_i,
    input logic ext_ack_i,
    input logic ext_wr_en_i,
    input logic ext_rd_en_i,
    input logic timeout_i
);
    // failure counts, one per property
    int unsigned pready_fail = 0;
    int unsigned req_fail = 0;
    int unsigned rw_fail = 0;

    // apb completion is a single cycle
    pready_single: assert property (@(posedge clk) disable iff (!rst_n)
        pready_i |=> !pready_i)
    else begin
        pready_fail = pready_fail + 1;
        $error("pready_o stayed high for more than one cycle");
    end

    // downstream request held until ack, a timeout may drop it
    ext_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        ext_req_i && !ext_ack_i && !timeout_i |=> ext_req_i)
    else begin
        req_fail = req_fail + 1;
        $error("ext_req_o dropped before ext_ack_i");
    end

    ext_rw_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(ext_wr_en_i && ext_rd_en_i))
    else begin
        rw_fail = rw_fail + 1;
        $error("ext_wr_en_o and ext_rd_en_o both high");
    end

endmodule

bind regmst_top regmst_asserts u_asrt (
    .clk         (clk),
    .rst_n       (rst_n),
    .pready_i    (pready_o),
    .ext_req_i   (ext_req_o),
    .ext_ack_i   (ext_ack_i),
    .ext_wr_en_i (ext_wr_en_o),
    .ext_rd_en_i (ext_rd_en_o),
    .timeout_i   (timeout)
);

// File: sim/regmst_tb.sv
`timescale 1ns/1ps
`include "regmst_consts.svh"

module regmst_tb
    import regmst_bus_pkg::*;
    import regmst_reg_pkg::*;
;
    // downstream model behavior per word address
    localparam logic [`REGMST_ADDR_W-3:0] HANG_WORD = 'h430;
    localparam logic [`REGMST_ADDR_W-3:0] ERR_WORD  = `REGMST_EXT_LAST_WORD;

    logic  clk;
    logic  rst_n;
    logic  psel_i;
    logic  penable_i;
    logic  pwrite_i;
    addr_t paddr_i;
    data_t pwdata_i;
    logic  pready_o;
    logic  pslverr_o;
    data_t prdata_o;
    logic  ext_req_o;
    logic  ext_wr_en_o;
    logic  ext_rd_en_o;
    addr_t ext_addr_o;
    data_t ext_wdata_o;
    logic  ext_ack_i;
    logic  ext_err_i;
    data_t ext_rdata_i;
    logic  ext_soft_rst_o;

    // last write seen by the downstream model
    addr_t last_wr_addr;
    data_t last_wr_data;

    // stimulus table
    logic  tx_wr[$];
    addr_t tx_addr[$];
    data_t tx_wdata[$];
    data_t tx_rdata[$];
    logic  tx_err[$];
    logic  tx_srst[$];
    int    tbl_len = 0;

    data_t got_rdata;
    logic  got_err;

    regmst_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .prdata_o       (prdata_o),
        .ext_req_o      (ext_req_o),
        .ext_wr_en_o    (ext_wr_en_o),
        .ext_rd_en_o    (ext_rd_en_o),
        .ext_addr_o     (ext_addr_o),
        .ext_wdata_o    (ext_wdata_o),
        .ext_ack_i      (ext_ack_i),
        .ext_err_i      (ext_err_i),
        .ext_rdata_i    (ext_rdata_i),
        .ext_soft_rst_o (ext_soft_rst_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic data_t model_rdata(input addr_t a);
        return a[`REGMST_DATA_W-1:0] ^ 32'hA5A50000;
    endfunction

    function automatic addr_t dbg_addr(input reg_idx_e idx);
        return addr_t'(`REGMST_DBG_BASE_WORD + int'(idx)) << 2;
    endfunction

    function automatic logic is_ext(input addr_t a);
        return a[`REGMST_ADDR_W-1:2] <= `REGMST_EXT_LAST_WORD;
    endfunction

    // status word from its fields
    function automatic data_t stat_word(input logic srst, input logic occur,
                                        input logic [1:0] etype);
        err_stat_t s;
        s = '0;
        s.soft_rst  = srst;
        s.err_occur = occur;
        s.err_type  = etype;
        return data_t'(s);
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic add_tx(input logic wr, input addr_t addr, input data_t wdata,
                          input data_t rdata, input logic err, input logic srst);
        tx_wr.push_back(wr);
        tx_addr.push_back(addr);
        tx_wdata.push_back(wdata);
        tx_rdata.push_back(rdata);
        tx_err.push_back(err);
        tx_srst.push_back(srst);
    endtask

    task automatic build_table();
        // reset values
        add_tx(1'b0, dbg_addr(REG_TMR_THR), '0, `REGMST_TMR_THR_RST, 1'b0, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_STAT), '0, '0, 1'b0, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_ADDR_LO), '0, '0, 1'b0, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_ADDR_HI), '0, '0, 1'b0, 1'b0);
        // downstream traffic
        add_tx(1'b0, 64'h40, '0, model_rdata(64'h40), 1'b0, 1'b0);
        add_tx(1'b0, 64'h10BC, '0, model_rdata(64'h10BC), 1'b0, 1'b0);
        add_tx(1'b1, 64'h100, 32'h12345678, '0, 1'b0, 1'b0);
        add_tx(1'b1, 64'h0C, 32'hCAFE0011, '0, 1'b0, 1'b0);
        add_tx(1'b0, 64'h10C4, '0, model_rdata(64'h10C4), 1'b1, 1'b0);
        // empty slot
        add_tx(1'b0, 64'h3000, '0, '0, 1'b1, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_STAT), '0, stat_word(1'b0, 1'b0, 2'b00), 1'b0, 1'b0);
        add_tx(1'b1, 64'h3000, 32'h55, '0, 1'b1, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_STAT), '0, stat_word(1'b0, 1'b0, 2'b01), 1'b0, 1'b0);
        // short threshold, then hang the downstream port
        add_tx(1'b1, dbg_addr(REG_TMR_THR), 32'd5, '0, 1'b0, 1'b0);
        add_tx(1'b0, dbg_addr(REG_TMR_THR), '0, 32'd5, 1'b0, 1'b0);
        add_tx(1'b0, 64'h10C0, '0, '0, 1'b1, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_STAT), '0, stat_word(1'b0, 1'b1, 2'b10), 1'b0, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_ADDR_LO), '0, 32'h10C0, 1'b0, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_ADDR_HI), '0, '0, 1'b0, 1'b0);
        add_tx(1'b1, 64'h10C0, 32'h0BADF00D, '0, 1'b1, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_STAT), '0, stat_word(1'b0, 1'b1, 2'b11), 1'b0, 1'b0);
        // soft reset on and off
        add_tx(1'b1, dbg_addr(REG_ERR_STAT), 32'h3, '0, 1'b0, 1'b1);
        add_tx(1'b0, dbg_addr(REG_ERR_STAT), '0, stat_word(1'b1, 1'b1, 2'b11), 1'b0, 1'b1);
        add_tx(1'b1, dbg_addr(REG_ERR_STAT), 32'h0, '0, 1'b0, 1'b0);
        add_tx(1'b0, dbg_addr(REG_ERR_STAT), '0, stat_word(1'b0, 1'b0, 2'b11), 1'b0, 1'b0);
        add_tx(1'b0, 64'h44, '0, model_rdata(64'h44), 1'b0, 1'b0);
        tbl_len = tx_addr.size();
    endtask

    // one apb transfer, held until pready_o
    task automatic apb_transfer(input logic wr, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic err);
        @(posedge clk);
        #10;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #10;
        penable_i = 1'b1;
        @(negedge clk);
        while (!pready_o) @(negedge clk);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        #10;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    // downstream dispatcher with random latency
    initial begin : downstream_model
        int unsigned               lat;
        logic [`REGMST_ADDR_W-3:0] word;
        ext_ack_i    = 1'b0;
        ext_err_i    = 1'b0;
        ext_rdata_i  = '0;
        last_wr_addr = '0;
        last_wr_data = '0;
        forever begin
            @(negedge clk);
            if (ext_req_o) begin
                word = ext_addr_o[`REGMST_ADDR_W-1:2];
                if (word == HANG_WORD) begin
                    while (ext_req_o) @(negedge clk);
                end else begin
                    lat = $urandom_range(4, 1);
                    repeat (lat) @(posedge clk);
                    #10;
                    ext_ack_i   = 1'b1;
                    ext_err_i   = (word == ERR_WORD);
                    // read data only answers a read strobe
                    ext_rdata_i = ext_rd_en_o ? model_rdata(ext_addr_o) : '0;
                    if (ext_wr_en_o) begin
                        last_wr_addr = ext_addr_o;
                        last_wr_data = ext_wdata_o;
                    end
                    @(posedge clk);
                    #10;
                    ext_ack_i   = 1'b0;
                    ext_err_i   = 1'b0;
                    ext_rdata_i = '0;
                end
            end
        end
    end

    initial begin : watchdog
        wait (tbl_len != 0);
        repeat (tbl_len * (`REGMST_TMR_THR_RST + 10)) @(posedge clk);
        $display("watchdog expired before all transfers finished");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n     = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        void'($urandom(58));
        build_table();
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("pready_o", pready_o, 1'b0);
        check_flag("pslverr_o", pslverr_o, 1'b0);
        check_flag("ext_req_o", ext_req_o, 1'b0);
        check_flag("ext_wr_en_o", ext_wr_en_o, 1'b0);
        check_flag("ext_rd_en_o", ext_rd_en_o, 1'b0);
        check_flag("ext_soft_rst_o", ext_soft_rst_o, 1'b0);

        for (int i = 0; i < tbl_len; i++) begin
            apb_transfer(tx_wr[i], tx_addr[i], tx_wdata[i], got_rdata, got_err);
            check_flag("pslverr_o", got_err, tx_err[i]);
            if (!tx_wr[i]) begin
                check_data("prdata_o", got_rdata, tx_rdata[i]);
            end
            check_flag("ext_soft_rst_o", ext_soft_rst_o, tx_srst[i]);
            // downstream must have seen the write
            if (tx_wr[i] && is_ext(tx_addr[i]) && !tx_err[i]) begin
                check_addr("ext_addr_o", last_wr_addr, tx_addr[i]);
                check_data("ext_wdata_o", last_wr_data, tx_wdata[i]);
            end
        end

        repeat (2) @(posedge clk);
        if (dut0.u_asrt.pready_fail + dut0.u_asrt.req_fail + dut0.u_asrt.rw_fail == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "assertion failures were reported");
        end
    end

endmodule

// File: sim.f
+incdir+source
source/regmst_bus_pkg.sv
source/regmst_reg_pkg.sv
source/apb_access_fsm.sv
source/access_router.sv
source/debug_reg_bank.sv
source/regmst_top.sv
sim/regmst_asserts.sv
sim/regmst_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module regmst_tb -f sim.f -o regmst_sim

sim_out=$(./obj_dir/regmst_sim +verilator+error+limit+100 2>&1 || true)
echo "$sim_out"

if grep -qF -- "*** PASSED ***" <<< "$sim_out"; then
    exit 0
fi
exit 1
